//--- rtl/cpuPkg.sv
package cpuPkg;

    localparam int DataWidth   = 32;
    localparam int AddrWidth   = 9;
    localparam int MemDepth    = 512;
    localparam int RegCount    = 16;
    localparam int RegSelWidth = 4;
    localparam int OpcodeWidth = 5;

    // Instruction field positions
    localparam int OpMsb      = 31;
    localparam int RaMsb      = 26;
    localparam int RbMsb      = 22;
    localparam int RcMsb      = 18;
    localparam int CondMsb    = 20;  // CON condition in bits 20..19
    localparam int ConstWidth = 19;

    typedef enum logic [OpcodeWidth-1:0] {
        opAdd = 5'b00011,
        opAnd = 5'b01011,
        opOr  = 5'b01010,
        opInc = 5'b11111   // Never in an instruction, only selected by IncPC
    } aluOpT;

    typedef enum logic [1:0] {
        condZero     = 2'b00,
        condNonZero  = 2'b01,
        condPositive = 2'b10,
        condNegative = 2'b11
    } conCondT;

endpackage

//--- rtl/memBusIf.sv
interface memBusIf;

    logic [cpuPkg::AddrWidth-1:0] address;
    logic [cpuPkg::DataWidth-1:0] writeData;
    logic [cpuPkg::DataWidth-1:0] readData;
    logic                         read;
    logic                         write;
    logic                         enable;
    logic                         done;   // One-cycle pulse after each enable

    modport master (
        output address,
        output writeData,
        output read,
        output write,
        output enable,
        input  readData,
        input  done
    );

    modport slave (
        input  address,
        input  writeData,
        input  read,
        input  write,
        input  enable,
        output readData,
        output done
    );

endinterface

//--- rtl/memoryUnit.sv
module memoryUnit (
    input  logic                         Clock,
    input  logic                         rst,
    memBusIf.slave                       mem,
    input  logic                         memOverride,
    input  logic [cpuPkg::AddrWidth-1:0] overrideAddress,
    input  logic [cpuPkg::DataWidth-1:0] overrideDataIn
);

    logic [cpuPkg::DataWidth-1:0] memArray [cpuPkg::MemDepth];
    logic [cpuPkg::AddrWidth-1:0] effAddr;
    logic [cpuPkg::DataWidth-1:0] effData;
    logic [cpuPkg::DataWidth-1:0] readHold;
    logic                         writeEn;
    logic                         readEn;

    // Loading port wins over the datapath side
    assign effAddr = memOverride ? overrideAddress : mem.address;
    assign effData = memOverride ? overrideDataIn : mem.writeData;

    assign writeEn = mem.enable & (mem.write | memOverride);
    assign readEn  = mem.enable & mem.read & ~memOverride;

    always_ff @(posedge Clock) begin
        if (writeEn) begin
            memArray[effAddr] <= effData;
        end
        if (readEn) begin
            readHold <= memArray[effAddr];  // Word kept for the done cycle
        end
    end

    // The word is visible during the enable cycle so the MDR can take it
    // on the same edge that raises done, and it is held afterwards.
    assign mem.readData = readEn ? memArray[effAddr] : readHold;

    always_ff @(posedge Clock) begin
        if (rst) begin
            mem.done <= 1'b0;
        end else begin
            mem.done <= mem.enable;  // Done follows enable by one cycle
        end
    end

endmodule

//--- rtl/registerFile.sv
module registerFile (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic [cpuPkg::DataWidth-1:0] ir,
    input  logic                         gra,
    input  logic                         grb,
    input  logic                         grc,
    input  logic                         rin,
    input  logic                         baOut,
    input  logic [cpuPkg::DataWidth-1:0] busIn,
    output logic [cpuPkg::DataWidth-1:0] regOut
);

    logic [cpuPkg::DataWidth-1:0]   regs [cpuPkg::RegCount];
    logic [cpuPkg::RegSelWidth-1:0] regSel;

    // Select decode from the IR fields
    always_comb begin
        if (gra) begin
            regSel = ir[cpuPkg::RaMsb -: cpuPkg::RegSelWidth];
        end else if (grb) begin
            regSel = ir[cpuPkg::RbMsb -: cpuPkg::RegSelWidth];
        end else if (grc) begin
            regSel = ir[cpuPkg::RcMsb -: cpuPkg::RegSelWidth];
        end else begin
            regSel = '0;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rin) begin
            regs[regSel] <= busIn;
        end
    end

    // Base address rule: r0 reads as zero only under BAout
    always_comb begin
        if (baOut && (regSel == '0)) begin
            regOut = '0;
        end else begin
            regOut = regs[regSel];
        end
    end

endmodule

//--- rtl/aluUnit.sv
module aluUnit (
    input  logic                         Clock,
    input  logic                         rst,
    input  logic [cpuPkg::DataWidth-1:0] busIn,
    input  logic                         yin,
    input  logic                         zin,
    input  cpuPkg::aluOpT                opcode,
    input  logic                         incPc,
    output logic [cpuPkg::DataWidth-1:0] zHi,
    output logic [cpuPkg::DataWidth-1:0] zLo
);

    logic [cpuPkg::DataWidth-1:0]   yReg;
    logic [2*cpuPkg::DataWidth-1:0] zReg;
    logic [2*cpuPkg::DataWidth-1:0] result;
    logic [cpuPkg::DataWidth:0]     sum;
    cpuPkg::aluOpT                  aluOp;

    assign aluOp = incPc ? cpuPkg::opInc : opcode;  // IncPC overrides the opcode
    assign sum   = {1'b0, yReg} + {1'b0, busIn};

    always_comb begin
        result = '0;
        case (aluOp)
            cpuPkg::opAdd: begin
                result = {{(cpuPkg::DataWidth-1){1'b0}}, sum};  // Carry lands in Z high
            end
            cpuPkg::opAnd: begin
                result[cpuPkg::DataWidth-1:0] = yReg & busIn;
            end
            cpuPkg::opOr: begin
                result[cpuPkg::DataWidth-1:0] = yReg | busIn;
            end
            cpuPkg::opInc: begin
                result[cpuPkg::DataWidth-1:0] = busIn + 1'b1;  // PC step
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            yReg <= '0;
            zReg <= '0;
        end else begin
            if (yin) begin
                yReg <= busIn;
            end
            if (zin) begin
                zReg <= result;
            end
        end
    end

    assign zHi = zReg[2*cpuPkg::DataWidth-1:cpuPkg::DataWidth];
    assign zLo = zReg[cpuPkg::DataWidth-1:0];

endmodule

//--- rtl/dataPath.sv
module dataPath (
    input  logic                         Clock,
    input  logic                         rst,
    memBusIf.master                      mem,
    input  logic                         hiOut,
    input  logic                         loOut,
    input  logic                         zHiOut,
    input  logic                         zLoOut,
    input  logic                         pcOut,
    input  logic                         mdrOut,
    input  logic                         inportOut,
    input  logic                         cOut,
    input  logic                         marIn,
    input  logic                         zIn,
    input  logic                         pcIn,
    input  logic                         mdrIn,
    input  logic                         irIn,
    input  logic                         yIn,
    input  logic                         hiIn,
    input  logic                         loIn,
    input  logic                         conIn,
    input  logic                         outportIn,
    input  cpuPkg::aluOpT                opcode,
    input  logic                         incPc,
    input  logic                         gra,
    input  logic                         grb,
    input  logic                         grc,
    input  logic                         rin,
    input  logic                         rout,
    input  logic                         baOut,
    input  logic                         memRead,
    input  logic                         memWrite,
    input  logic                         memEnable,
    input  logic [cpuPkg::DataWidth-1:0] inportData,
    input  logic                         inportDataReady,
    output logic [cpuPkg::DataWidth-1:0] outportData,
    output logic                         conFfBit,
    output logic [cpuPkg::AddrWidth-1:0] marAddress
);

    logic [cpuPkg::DataWidth-1:0] busData;
    logic [cpuPkg::DataWidth-1:0] pcReg, mdrReg, irReg, hiReg, loReg;
    logic [cpuPkg::DataWidth-1:0] inportReg, outportReg;
    logic [cpuPkg::AddrWidth-1:0] marReg;
    logic [cpuPkg::DataWidth-1:0] regOut, zHi, zLo, cValue;
    cpuPkg::conCondT              cond;
    logic                         condMet;

    registerFile regFile (
        .Clock (Clock),
        .rst   (rst),
        .ir    (irReg),
        .gra   (gra),
        .grb   (grb),
        .grc   (grc),
        .rin   (rin),
        .baOut (baOut),
        .busIn (busData),
        .regOut(regOut)
    );

    aluUnit alu (
        .Clock (Clock),
        .rst   (rst),
        .busIn (busData),
        .yin   (yIn),
        .zin   (zIn),
        .opcode(opcode),
        .incPc (incPc),
        .zHi   (zHi),
        .zLo   (zLo)
    );

    // Sign-extended constant field
    assign cValue = {{(cpuPkg::DataWidth-cpuPkg::ConstWidth){irReg[cpuPkg::ConstWidth-1]}},
                     irReg[cpuPkg::ConstWidth-1:0]};

    // Shared bus, one source at a time
    always_comb begin
        busData = '0;
        if (hiOut) begin
            busData = hiReg;
        end else if (loOut) begin
            busData = loReg;
        end else if (zHiOut) begin
            busData = zHi;
        end else if (zLoOut) begin
            busData = zLo;
        end else if (pcOut) begin
            busData = pcReg;
        end else if (mdrOut) begin
            busData = mdrReg;
        end else if (inportOut) begin
            busData = inportReg;
        end else if (cOut) begin
            busData = cValue;
        end else if (rout || baOut) begin
            busData = regOut;
        end
    end

    // Branch condition on the value driven by Ra
    assign cond = cpuPkg::conCondT'(irReg[cpuPkg::CondMsb -: 2]);

    always_comb begin
        case (cond)
            cpuPkg::condZero:     condMet = (busData == '0);
            cpuPkg::condNonZero:  condMet = (busData != '0);
            cpuPkg::condPositive: condMet = !busData[cpuPkg::DataWidth-1] && (busData != '0);
            default:              condMet = busData[cpuPkg::DataWidth-1];  // Negative
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            pcReg      <= '0;
            marReg     <= '0;
            mdrReg     <= '0;
            irReg      <= '0;
            hiReg      <= '0;
            loReg      <= '0;
            inportReg  <= '0;
            outportReg <= '0;
            conFfBit   <= 1'b0;
        end else begin
            if (pcIn)            pcReg      <= busData;
            if (marIn)           marReg     <= busData[cpuPkg::AddrWidth-1:0];
            if (irIn)            irReg      <= busData;
            if (hiIn)            hiReg      <= busData;
            if (loIn)            loReg      <= busData;
            if (outportIn)       outportReg <= busData;
            if (inportDataReady) inportReg  <= inportData;
            if (conIn)           conFfBit   <= condMet;
            if (mdrIn) begin
                mdrReg <= memRead ? mem.readData : busData;  // Memory word or bus
            end
        end
    end

    assign mem.address   = marReg;
    assign mem.writeData = mdrReg;
    assign mem.read      = memRead;
    assign mem.write     = memWrite;
    assign mem.enable    = memEnable;

    assign outportData = outportReg;
    assign marAddress  = marReg;

endmodule

//--- rtl/cpuSystem.sv
module cpuSystem (
    input  logic                           Clock,
    input  logic                           rst,
    input  logic                           hiOut,
    input  logic                           loOut,
    input  logic                           zHiOut,
    input  logic                           zLoOut,
    input  logic                           pcOut,
    input  logic                           mdrOut,
    input  logic                           inportOut,
    input  logic                           cOut,
    input  logic                           marIn,
    input  logic                           zIn,
    input  logic                           pcIn,
    input  logic                           mdrIn,
    input  logic                           irIn,
    input  logic                           yIn,
    input  logic                           hiIn,
    input  logic                           loIn,
    input  logic                           conIn,
    input  logic                           outportIn,
    input  logic [cpuPkg::OpcodeWidth-1:0] opcode,
    input  logic                           incPc,
    input  logic                           gra,
    input  logic                           grb,
    input  logic                           grc,
    input  logic                           rin,
    input  logic                           rout,
    input  logic                           baOut,
    input  logic                           memRead,
    input  logic                           memWrite,
    input  logic                           memEnable,
    input  logic [cpuPkg::DataWidth-1:0]   inportData,
    input  logic                           inportDataReady,
    input  logic                           memOverride,
    input  logic [cpuPkg::AddrWidth-1:0]   overrideAddress,
    input  logic [cpuPkg::DataWidth-1:0]   overrideDataIn,
    output logic [cpuPkg::DataWidth-1:0]   memToDatapath,
    output logic [cpuPkg::DataWidth-1:0]   memDataToChip,
    output logic [cpuPkg::AddrWidth-1:0]   marAddress,
    output logic                           memoryDone,
    output logic [cpuPkg::DataWidth-1:0]   outportData,
    output logic                           conFfBit
);

    memBusIf memBus ();

    dataPath core (
        .Clock(Clock), .rst(rst), .mem(memBus.master),
        .hiOut(hiOut), .loOut(loOut), .zHiOut(zHiOut), .zLoOut(zLoOut),
        .pcOut(pcOut), .mdrOut(mdrOut), .inportOut(inportOut), .cOut(cOut),
        .marIn(marIn), .zIn(zIn), .pcIn(pcIn), .mdrIn(mdrIn), .irIn(irIn),
        .yIn(yIn), .hiIn(hiIn), .loIn(loIn), .conIn(conIn), .outportIn(outportIn),
        .opcode(cpuPkg::aluOpT'(opcode)), .incPc(incPc),  // Raw bits to opcode enum
        .gra(gra), .grb(grb), .grc(grc), .rin(rin), .rout(rout), .baOut(baOut),
        .memRead(memRead), .memWrite(memWrite), .memEnable(memEnable),
        .inportData(inportData), .inportDataReady(inportDataReady),
        .outportData(outportData), .conFfBit(conFfBit), .marAddress(marAddress)
    );

    memoryUnit ram (
        .Clock          (Clock),
        .rst            (rst),
        .mem            (memBus.slave),
        .memOverride    (memOverride),
        .overrideAddress(overrideAddress),
        .overrideDataIn (overrideDataIn)
    );

    // Memory side taps for observation
    assign memToDatapath = memBus.readData;
    assign memDataToChip = memBus.writeData;
    assign memoryDone    = memBus.done;

endmodule

//--- verification/cpuSystem_asserts.sv
module cpuSystemAsserts (
    input logic                         Clock,
    input logic                         rst,
    input logic                         memEnable,
    input logic                         memRead,
    input logic                         memOverride,
    input logic [cpuPkg::AddrWidth-1:0] overrideAddress,
    input logic [cpuPkg::DataWidth-1:0] overrideDataIn,
    input logic [cpuPkg::DataWidth-1:0] memToDatapath,
    input logic [cpuPkg::DataWidth-1:0] memDataToChip,
    input logic [cpuPkg::AddrWidth-1:0] marAddress,
    input logic                         memoryDone,
    input logic                         pcOut,
    input logic                         incPc,
    input logic                         marIn,
    input logic                         mdrIn,
    input logic                         irIn,
    input logic [cpuPkg::DataWidth-1:0] inportData,
    input logic                         inportDataReady,
    input logic                         outportIn,
    input logic                         gra,
    input logic                         rout,
    input logic                         baOut,
    input logic                         conIn,
    input logic [cpuPkg::DataWidth-1:0] outportData,
    input logic                         conFfBit
);
    timeunit 1ns;
    timeprecision 10ps;

    logic [cpuPkg::DataWidth-1:0]   shadowMem [cpuPkg::MemDepth];
    logic [cpuPkg::MemDepth-1:0]    shadowValid = '0;
    logic [cpuPkg::DataWidth-1:0]   irShadow, inportShadow, constExt, aluExpected, aluExpectedQ;
    logic [cpuPkg::DataWidth-1:0]   readExpected, mdrExpectedQ;
    logic [cpuPkg::AddrWidth-1:0]   fetchCount;
    logic [cpuPkg::OpcodeWidth-1:0] irOp;
    logic                           isAluIr, conExpected, conExpectedQ, enableQ, readKnown;
    bit failReset = 1'b0;
    bit failDone  = 1'b0;
    bit failRead  = 1'b0;
    bit failMdr   = 1'b0;
    bit failFetch = 1'b0;
    bit failAlu   = 1'b0;
    bit failCon   = 1'b0;
    bit failBa    = 1'b0;
    logic anyFail;

    always_ff @(posedge Clock) begin
        enableQ <= memEnable;
        if (memOverride && memEnable) begin
            shadowMem[overrideAddress]   <= overrideDataIn;  // Words loaded through override
            shadowValid[overrideAddress] <= 1'b1;
        end
        if (mdrIn && memRead) mdrExpectedQ <= readExpected;  // Word the MDR should take
        if (conIn) conExpectedQ <= conExpected;
        if (outportIn) aluExpectedQ <= aluExpected;
        if (rst) begin
            irShadow     <= '0;
            inportShadow <= '0;
            fetchCount   <= '0;
        end else begin
            if (irIn) irShadow <= mdrExpectedQ;  // Word read in the previous step
            if (inportDataReady) inportShadow <= inportData;
            if (pcOut && incPc && marIn) fetchCount <= fetchCount + cpuPkg::AddrWidth'(1);
        end
    end

    assign readExpected = shadowMem[marAddress];
    assign readKnown    = shadowValid[marAddress];
    assign irOp         = irShadow[cpuPkg::OpMsb -: cpuPkg::OpcodeWidth];
    assign constExt     = {{(cpuPkg::DataWidth-cpuPkg::ConstWidth){irShadow[cpuPkg::ConstWidth-1]}},
                           irShadow[cpuPkg::ConstWidth-1:0]};
    assign isAluIr      = (irOp == cpuPkg::opAdd) || (irOp == cpuPkg::opAnd) || (irOp == cpuPkg::opOr);

    // Reference results for the immediate forms and the branch conditions
    always_comb begin
        if (irOp == cpuPkg::opAdd) aluExpected = inportShadow + constExt;
        else if (irOp == cpuPkg::opAnd) aluExpected = inportShadow & constExt;
        else aluExpected = inportShadow | constExt;
        case (irShadow[cpuPkg::CondMsb -: 2])
            2'b00:   conExpected = (inportShadow == '0);
            2'b01:   conExpected = (inportShadow != '0);
            2'b10:   conExpected = ($signed(inportShadow) > 0);
            default: conExpected = ($signed(inportShadow) < 0);
        endcase
    end

    assign anyFail = failReset | failDone | failRead | failMdr | failFetch | failAlu | failCon |
                     failBa;

    resetClear: assert property (@(posedge Clock) $fell(rst) |->
            (!memoryDone && !conFfBit && outportData == '0 && marAddress == '0))
        else begin
            failReset = 1'b1;
            $error("FAIL at %0t: reset left memoryDone=%b conFfBit=%b outportData=%h marAddress=%h",
                   $time, $sampled(memoryDone), $sampled(conFfBit), $sampled(outportData),
                   $sampled(marAddress));
        end

    doneLatency: assert property (@(posedge Clock) disable iff (rst) memoryDone == enableQ)
        else begin
            failDone = 1'b1;
            $error("FAIL at %0t: memoryDone = %b, expected %b", $time, $sampled(memoryDone),
                   $sampled(enableQ));
        end

    readData: assert property (@(posedge Clock) disable iff (rst)
            (memEnable && memRead && !memOverride) |-> (readKnown && memToDatapath == readExpected))
        else begin
            failRead = 1'b1;
            $error("FAIL at %0t: memToDatapath = %h, expected %h", $time, memToDatapath,
                   readExpected);
        end

    mdrLoad: assert property (@(posedge Clock) disable iff (rst)
            (mdrIn && memRead && memEnable && !memOverride) |=> memDataToChip == mdrExpectedQ)
        else begin
            failMdr = 1'b1;
            $error("FAIL at %0t: memDataToChip = %h, expected %h", $time, memDataToChip,
                   mdrExpectedQ);
        end

    fetchAddr: assert property (@(posedge Clock) disable iff (rst)
            (pcOut && incPc && marIn) |=> marAddress == fetchCount - cpuPkg::AddrWidth'(1))
        else begin
            failFetch = 1'b1;
            $error("FAIL at %0t: marAddress = %0d, expected %0d", $time, marAddress,
                   fetchCount - cpuPkg::AddrWidth'(1));
        end

    immediateResult: assert property (@(posedge Clock) disable iff (rst)
            (outportIn && gra && rout && !baOut && isAluIr) |=> outportData == aluExpectedQ)
        else begin
            failAlu = 1'b1;
            $error("FAIL at %0t: outportData = %h, expected %h", $time, outportData, aluExpectedQ);
        end

    conResult: assert property (@(posedge Clock) disable iff (rst)
            conIn |=> conFfBit == conExpectedQ)
        else begin
            failCon = 1'b1;
            $error("FAIL at %0t: conFfBit = %b, expected %b", $time, conFfBit, conExpectedQ);
        end

    baseZero: assert property (@(posedge Clock) disable iff (rst)
            (baOut && outportIn) |=> outportData == '0)
        else begin
            failBa = 1'b1;
            $error("FAIL at %0t: outportData = %h, expected 0", $time, outportData);
        end

endmodule

bind cpuSystem cpuSystemAsserts checks (.*);

//--- verification/cpuSystemTb.sv
module cpuSystemTb;
    timeunit 1ns;
    timeprecision 10ps;

    localparam int CycleLimit = 200;  // Full run is about 90 cycles

    logic Clock;
    logic rst;
    logic hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut;
    logic marIn, zIn, pcIn, mdrIn, irIn, yIn, hiIn, loIn, conIn, outportIn;
    logic incPc, gra, grb, grc, rin, rout, baOut;
    logic memRead, memWrite, memEnable, inportDataReady, memOverride;
    logic [cpuPkg::OpcodeWidth-1:0] opcode;
    logic [cpuPkg::DataWidth-1:0]   inportData, overrideDataIn;
    logic [cpuPkg::AddrWidth-1:0]   overrideAddress;
    logic [cpuPkg::DataWidth-1:0]   memToDatapath, memDataToChip, outportData;
    logic [cpuPkg::AddrWidth-1:0]   marAddress;
    logic                           memoryDone, conFfBit;

    logic [31:0]                    lcgState = 32'ha1bc_74a2;
    logic [cpuPkg::DataWidth-1:0]   image [8];
    logic [cpuPkg::OpcodeWidth-1:0] aluOps [3];
    int                             cycleCount = 0;

    cpuSystem UUT (.*);

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic abortRun(input string reason);
        $display("FAIL: see errors above");
        $fatal(1, "%s", reason);
    endtask

    task automatic clearStrobes();
        {hiOut, loOut, zHiOut, zLoOut, pcOut, mdrOut, inportOut, cOut,
         marIn, zIn, pcIn, mdrIn, irIn, yIn, hiIn, loIn, conIn, outportIn,
         incPc, gra, grb, grc, rin, rout, baOut,
         memRead, memWrite, memEnable, inportDataReady, memOverride} = '0;
    endtask

    task automatic nextStep();  // New micro-step starts at the falling edge
        @(negedge Clock);
        clearStrobes();
    endtask

    task automatic writeWord(input logic [cpuPkg::AddrWidth-1:0] addr,
                             input logic [cpuPkg::DataWidth-1:0] word);
        nextStep();
        {memOverride, memEnable} = '1;
        overrideAddress = addr;
        overrideDataIn  = word;
    endtask

    task automatic fetchInstruction();
        nextStep();
        {pcOut, marIn, incPc, zIn} = '1;                 // T0
        nextStep();
        {zLoOut, pcIn, memRead, memEnable, mdrIn} = '1;  // T1
        nextStep();
        {mdrOut, irIn} = '1;                             // T2
    endtask

    task automatic loadRegister(input logic [cpuPkg::DataWidth-1:0] value, input bit useRa);
        nextStep();
        inportData      = value;
        inportDataReady = 1'b1;
        nextStep();
        {inportOut, rin} = '1;
        gra = useRa;
        grb = !useRa;
    endtask

    task automatic runImmediate(input logic [cpuPkg::OpcodeWidth-1:0] op);
        nextStep();
        {grb, rout, yIn} = '1;       // T3
        nextStep();
        {cOut, zIn} = '1;            // T4
        opcode = op;
        nextStep();
        {zLoOut, gra, rin} = '1;     // T5
        nextStep();
        {gra, rout, outportIn} = '1;  // Result to the out port
    endtask

    task automatic applyCondition(input logic [cpuPkg::DataWidth-1:0] value);
        loadRegister(value, 1'b1);
        nextStep();
        {gra, rout, conIn} = '1;
    endtask

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) abortRun("timeout: the test sequence did not complete");
    end

    always @(negedge Clock) begin
        if (UUT.checks.anyFail) abortRun("an assertion in the checker failed");
    end

    initial begin
        clearStrobes();
        opcode          = '0;
        inportData      = '0;
        overrideAddress = '0;
        overrideDataIn  = '0;
        rst             = 1'b1;
        aluOps[0] = cpuPkg::opAdd;
        aluOps[1] = cpuPkg::opAnd;
        aluOps[2] = cpuPkg::opOr;
        for (int i = 0; i < 3; i++) begin
            image[i] = {aluOps[i], 4'(i + 2), 4'd1, 19'(nextRandom())};  // Ra = r2..r4, Rb = r1
        end
        for (int i = 0; i < 4; i++) begin
            image[3 + i] = {5'b10010, 4'd5, 2'b00, 2'(i), 19'd0};  // Branch on r5, one per cond
        end
        image[7] = {5'b00000, 4'd0, 23'd0};  // Ra field selects r0
        repeat (2) @(negedge Clock);
        rst = 1'b0;

        for (int i = 0; i < 8; i++) begin
            writeWord(i[cpuPkg::AddrWidth-1:0], image[i]);
        end

        fetchInstruction();
        loadRegister(nextRandom(), 1'b0);  // Rb operand shared by all three
        runImmediate(aluOps[0]);
        for (int i = 1; i < 3; i++) begin
            fetchInstruction();
            runImmediate(aluOps[i]);
        end

        for (int c = 0; c < 4; c++) begin
            fetchInstruction();
            applyCondition('0);
            applyCondition((nextRandom() >> 1) | 32'd1);    // Positive
            applyCondition(nextRandom() | 32'h8000_0000);  // Negative
        end

        fetchInstruction();
        loadRegister(nextRandom() | 32'd1, 1'b1);  // r0 made non-zero
        nextStep();
        {gra, baOut, outportIn} = '1;
        repeat (3) nextStep();

        if (UUT.checks.anyFail) begin
            abortRun("an assertion in the checker failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

//--- files.f
rtl/cpuPkg.sv
rtl/memBusIf.sv
rtl/memoryUnit.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/dataPath.sv
rtl/cpuSystem.sv
verification/cpuSystem_asserts.sv
verification/cpuSystemTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuSystemTb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
SIMARGS   ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIMARGS)

clean:
	rm -rf $(BUILD_DIR)
